/* files.f */
+incdir+verilog
verilog/mem_pkg.sv
verilog/mem_issue.sv
verilog/mem_req_fifo.sv
verilog/mem_stage.sv
verilog/mem_subsystem_top.sv
verification/mem_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= mem_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
FAIL_MSG  ?= Verification failed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with verilator, run it, scan $(LOG) for failure"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	exit $$rc

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/mem_tb.sv */
`include "mem_defs.svh"

module mem_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import mem_pkg::*;

  localparam int WAIT_LIMIT = 2000;
  localparam logic [1:0] READY_LOW = 2'd0;
  localparam logic [1:0] READY_HIGH = 2'd1;
  localparam logic [1:0] READY_RANDOM = 2'd2;

  logic                   clk;
  logic                   reset;
  logic                   cmd_valid;
  logic                   cmd_ready;
  mem_op_e                cmd_op;
  wsrc_e                  cmd_wsrc;
  logic [`MEM_ADDR_W-1:0] cmd_addr;
  logic [`MEM_DATA_W-1:0] cmd_reg_data;
  logic                   cmd_restore_flags;
  logic [`PC_W-1:0]       pc;
  logic [`FLAGS_W-1:0]    flags;
  mem_resp_t              resp;
  logic                   resp_valid;
  logic                   resp_ready;

  // model state advances when a command is accepted
  logic [`MEM_DATA_W-1:0] model_mem [`MEM_DEPTH];
  logic [`SP_W-1:0]       model_sp;
  mem_tag_t               next_tag;
  mem_resp_t              expected_q [$];
  logic [1:0]             ready_mode;
  int                     errors;
  int                     checks;

  mem_subsystem_top UUT (
    .clk               (clk),
    .reset             (reset),
    .cmd_valid         (cmd_valid),
    .cmd_ready         (cmd_ready),
    .cmd_op            (cmd_op),
    .cmd_wsrc          (cmd_wsrc),
    .cmd_addr          (cmd_addr),
    .cmd_reg_data      (cmd_reg_data),
    .cmd_restore_flags (cmd_restore_flags),
    .pc                (pc),
    .flags             (flags),
    .resp              (resp),
    .resp_valid        (resp_valid),
    .resp_ready        (resp_ready)
  );

  always #10 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    checks++;
    if (got !== want)
    begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, want);
    end
  endtask

  // write word as the issue side should pick it
  function automatic logic [`MEM_DATA_W-1:0] select_wdata(wsrc_e ws, logic [`PC_W-1:0] pc_v,
      logic [`FLAGS_W-1:0] fl, logic [`MEM_DATA_W-1:0] rd);
    case (ws)
      wsrc_flags: return {{(`MEM_DATA_W - `FLAGS_W){1'b0}}, fl};
      wsrc_pc_hi: return pc_v[`PC_W-1:`PC_W/2];
      wsrc_pc_lo: return pc_v[`PC_W/2-1:0];
      default:    return rd;
    endcase
  endfunction

  // reference memory and stack that faults leave untouched
  function automatic mem_resp_t model_step(mem_op_e op, logic [`MEM_ADDR_W-1:0] a,
      logic [`MEM_DATA_W-1:0] wd, logic rf, mem_tag_t tag);
    mem_resp_t r;
    r = '0;
    r.op = op;
    r.tag = tag;
    case (op)
      op_load:
        r.word.data = model_mem[a];
      op_store:
      begin
        model_mem[a] = wd;
        r.word.data = wd;
      end
      op_push:
      begin
        r.word.data = wd;
        if (model_sp == '0)
          r.fault = 1'b1;
        else
        begin
          model_sp = model_sp - `SP_W'(1);
          model_mem[model_sp[`MEM_ADDR_W-1:0]] = wd;
        end
      end
      default:
      begin
        // pop returns a zero word on an empty stack
        if (model_sp == `SP_W'(`MEM_DEPTH))
          r.fault = 1'b1;
        else
        begin
          r.word.data = model_mem[model_sp[`MEM_ADDR_W-1:0]];
          model_sp = model_sp + `SP_W'(1);
          if (rf)
          begin
            r.flags_valid = 1'b1;
            r.flags = r.word.data[`FLAGS_W-1:0];
          end
        end
      end
    endcase
    return r;
  endfunction

  // starts on a falling edge and ends on one with cmd_valid low
  task automatic send_cmd(input mem_op_e op, input wsrc_e ws, input logic [`MEM_ADDR_W-1:0] a,
                          input logic [`MEM_DATA_W-1:0] rd, input logic rf);
    int waited;
    waited = 0;
    cmd_valid = 1'b1;
    cmd_op = op;
    cmd_wsrc = ws;
    cmd_addr = a;
    cmd_reg_data = rd;
    cmd_restore_flags = rf;
    pc = $urandom;
    flags = `FLAGS_W'($urandom);
    // credits only move on rising edges
    while (!cmd_ready && waited < WAIT_LIMIT)
    begin
      @(negedge clk);
      waited++;
    end
    if (cmd_ready)
    begin
      expected_q.push_back(model_step(op, a, select_wdata(ws, pc, flags, rd), rf, next_tag));
      next_tag = next_tag + 4'd1;
    end
    else
    begin
      errors++;
      $display("timeout: cmd_ready stayed low for %0d cycles at %0t", waited, $time);
    end
    @(negedge clk);
    cmd_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (expected_q.size() != 0 && waited < WAIT_LIMIT)
    begin
      @(negedge clk);
      waited++;
    end
    if (expected_q.size() != 0)
    begin
      errors++;
      $display("timeout: %0d responses never arrived", expected_q.size());
    end
  endtask

  // mode changes land between falling edges
  task automatic set_ready_mode(input logic [1:0] mode);
    @(posedge clk);
    ready_mode = mode;
    @(negedge clk);
  endtask

  task automatic compare_resp();
    mem_resp_t want;
    if (expected_q.size() == 0)
    begin
      errors++;
      $display("response with tag %h arrived with no command outstanding", resp.tag);
    end
    else
    begin
      want = expected_q.pop_front();
      check_value("resp.op", 32'(resp.op), 32'(want.op));
      check_value("resp.tag", 32'(resp.tag), 32'(want.tag));
      check_value("resp.word", 32'(resp.word.data), 32'(want.word.data));
      check_value("resp.flags_valid", 32'(resp.flags_valid), 32'(want.flags_valid));
      check_value("resp.flags", 32'(resp.flags), 32'(want.flags));
      check_value("resp.fault", 32'(resp.fault), 32'(want.fault));
    end
  endtask

  // drives resp_ready and checks the handshake due at the next rising edge
  initial
  begin
    resp_ready = 1'b0;
    forever
    begin
      @(negedge clk);
      if (reset || ready_mode == READY_LOW)
        resp_ready = 1'b0;
      else if (ready_mode == READY_HIGH)
        resp_ready = 1'b1;
      else
        resp_ready = ($urandom_range(0, 3) != 0);
      if (resp_valid && resp_ready)
        compare_resp();
    end
  end

  initial
  begin
    logic [`MEM_ADDR_W-1:0] addrs [8];
    logic [`MEM_ADDR_W-1:0] a;
    int n_stall;
    void'($urandom(32'h9855c9b1));
    clk = 1'b0;
    reset = 1'b1;
    cmd_valid = 1'b0;
    cmd_op = op_load;
    cmd_wsrc = wsrc_reg;
    cmd_addr = '0;
    cmd_reg_data = '0;
    cmd_restore_flags = 1'b0;
    pc = '0;
    flags = '0;
    ready_mode = READY_HIGH;
    next_tag = '0;
    errors = 0;
    checks = 0;
    model_sp = `SP_W'(`MEM_DEPTH);
    for (int i = 0; i < `MEM_DEPTH; i++)
      model_mem[i] = '0;
    repeat (16) @(negedge clk);
    reset = 1'b0;
    check_value("cmd_ready", 32'(cmd_ready), 32'd1);
    check_value("resp_valid", 32'(resp_valid), 32'd0);

    // pop on the empty stack
    send_cmd(op_pop, wsrc_reg, '0, '0, 1'b1);

    // fill pattern over every address
    for (int i = 0; i < `MEM_DEPTH; i++)
    begin
      a = `MEM_ADDR_W'(i);
      send_cmd(op_store, wsrc_reg, a, {7'h5a, a} ^ {a[6:0], 9'd0}, 1'b0);
    end

    // stores then loads at random addresses
    for (int i = 0; i < 8; i++)
    begin
      addrs[i] = `MEM_ADDR_W'($urandom);
      send_cmd(op_store, wsrc_reg, addrs[i], `MEM_DATA_W'($urandom), 1'b0);
    end
    for (int i = 0; i < 8; i++)
      send_cmd(op_load, wsrc_reg, addrs[i], '0, 1'b0);

    // one push per write source then pops in lifo order
    for (int w = 0; w < 4; w++)
      send_cmd(op_push, wsrc_e'(w), '0, `MEM_DATA_W'($urandom), 1'b0);
    // every other pop restores flags
    for (int w = 0; w < 4; w++)
      send_cmd(op_pop, wsrc_reg, '0, '0, (w % 2) == 0);

    // only the 513th push overflows
    for (int i = 0; i <= `MEM_DEPTH; i++)
      send_cmd(op_push, wsrc_reg, '0, `MEM_DATA_W'($urandom), 1'b0);
    wait_drain();

    // back-pressure fills the buffer and uses up the credits
    set_ready_mode(READY_LOW);
    n_stall = 0;
    while (cmd_ready && n_stall < `REQ_FIFO_DEPTH + 1)
    begin
      send_cmd(op_store, wsrc_reg, `MEM_ADDR_W'($urandom), `MEM_DATA_W'($urandom), 1'b0);
      n_stall++;
    end
    if (cmd_ready)
    begin
      errors++;
      $display("cmd_ready still high after %0d commands with resp_ready low", n_stall);
    end
    set_ready_mode(READY_HIGH);
    wait_drain();

    // mixed traffic under random back-pressure
    set_ready_mode(READY_RANDOM);
    for (int i = 0; i < 400; i++)
    begin
      send_cmd(mem_op_e'($urandom_range(0, 3)), wsrc_e'($urandom_range(0, 3)),
               `MEM_ADDR_W'($urandom), `MEM_DATA_W'($urandom), ($urandom_range(0, 1) == 1));
      if ($urandom_range(0, 3) == 0)
        @(negedge clk);
    end
    wait_drain();

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

/* verilog/mem_subsystem_top.sv */
`include "mem_defs.svh"

module mem_subsystem_top (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    cmd_valid,
  output logic                    cmd_ready,
  input  mem_pkg::mem_op_e        cmd_op,
  input  mem_pkg::wsrc_e          cmd_wsrc,
  input  logic [`MEM_ADDR_W-1:0]  cmd_addr,
  input  logic [`MEM_DATA_W-1:0]  cmd_reg_data,
  input  logic                    cmd_restore_flags,
  input  logic [`PC_W-1:0]        pc,
  input  logic [`FLAGS_W-1:0]     flags,
  output mem_pkg::mem_resp_t      resp,
  output logic                    resp_valid,
  input  logic                    resp_ready
);

  import mem_pkg::*;

  // issue to buffer
  mem_req_t req;
  logic     req_push;
  logic     credit_return;

  // buffer to stage
  mem_req_t head;
  logic     head_valid;
  logic     head_pop;

  mem_issue u_issue (
    .clk               (clk),
    .reset             (reset),
    .cmd_valid         (cmd_valid),
    .cmd_ready         (cmd_ready),
    .cmd_op            (cmd_op),
    .cmd_wsrc          (cmd_wsrc),
    .cmd_addr          (cmd_addr),
    .cmd_reg_data      (cmd_reg_data),
    .cmd_restore_flags (cmd_restore_flags),
    .pc                (pc),
    .flags             (flags),
    .credit_return     (credit_return),
    .req               (req),
    .req_push          (req_push)
  );

  // credit per popped entry goes back to issue
  mem_req_fifo u_req_fifo (
    .clk           (clk),
    .reset         (reset),
    .req_push      (req_push),
    .req           (req),
    .head          (head),
    .head_valid    (head_valid),
    .head_pop      (head_pop),
    .credit_return (credit_return)
  );

  mem_stage u_stage (
    .clk        (clk),
    .reset      (reset),
    .head       (head),
    .head_valid (head_valid),
    .head_pop   (head_pop),
    .resp       (resp),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready)
  );

endmodule

/* verilog/mem_stage.sv */
`include "mem_defs.svh"

module mem_stage (
  input  logic                clk,
  input  logic                reset,
  input  mem_pkg::mem_req_t   head,
  input  logic                head_valid,
  output logic                head_pop,
  output mem_pkg::mem_resp_t  resp,
  output logic                resp_valid,
  input  logic                resp_ready
);

  import mem_pkg::*;

  logic [`MEM_DATA_W-1:0] mem [`MEM_DEPTH];

  logic [`SP_W-1:0]       sp;
  logic [`SP_W-1:0]       sp_dec;
  logic [`MEM_ADDR_W-1:0] addr;
  logic [`MEM_DATA_W-1:0] rd_data;
  logic                   is_push;
  logic                   is_pop;
  logic                   fault;
  logic                   mem_we;
  mem_resp_t              resp_next;

  // take the head when the response slot is free or draining now
  assign head_pop = head_valid && (!resp_valid || resp_ready);

  assign is_push = (head.op == op_push);
  assign is_pop  = (head.op == op_pop);

  // push on a full stack, pop on an empty one
  assign fault = (is_push && (sp == '0)) ||
                 (is_pop && (sp == `SP_W'(`MEM_DEPTH)));

  // push writes below the current top
  assign sp_dec = sp - 1'b1;

  // address select by op
  always_comb
  begin
    case (head.op)
      op_push: addr = sp_dec[`MEM_ADDR_W-1:0];
      op_pop:  addr = sp[`MEM_ADDR_W-1:0];
      default: addr = head.addr;
    endcase
  end

  assign rd_data = mem[addr];
  assign mem_we  = head_pop && ((head.op == op_store) || (is_push && !fault));

  always_ff @(posedge clk)
  begin
    if (mem_we)
      mem[addr] <= head.wdata;
  end

  // stack pointer moves only on a good push or pop
  always_ff @(posedge clk)
  begin
    if (reset)
      sp <= `SP_W'(`MEM_DEPTH);
    else if (head_pop && !fault)
    begin
      if (is_push)
        sp <= sp_dec;
      else if (is_pop)
        sp <= sp + 1'b1;
    end
  end

  // response word and flags decode
  always_comb
  begin
    resp_next.op          = head.op;
    resp_next.tag         = head.tag;
    resp_next.fault       = fault;
    resp_next.flags_valid = 1'b0;
    resp_next.flags       = '0;
    case (head.op)
      op_load: resp_next.word.data = rd_data;
      // faulted pop returns zero
      op_pop:  resp_next.word.data = fault ? '0 : rd_data;
      // store and push echo what was written
      default: resp_next.word.data = head.wdata;
    endcase
    // same word seen as a saved flags image
    if (is_pop && head.restore_flags && !fault)
    begin
      resp_next.flags_valid = 1'b1;
      resp_next.flags       = resp_next.word.flag_view.flags;
    end
  end

  // response register, held while valid and not ready
  always_ff @(posedge clk)
  begin
    if (reset)
      resp_valid <= 1'b0;
    else if (head_pop)
      resp_valid <= 1'b1;
    else if (resp_ready)
      resp_valid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (head_pop)
      resp <= resp_next;
  end

endmodule

/* verilog/mem_req_fifo.sv */
`include "mem_defs.svh"

module mem_req_fifo (
  input  logic               clk,
  input  logic               reset,
  input  logic               req_push,
  input  mem_pkg::mem_req_t  req,
  output mem_pkg::mem_req_t  head,
  output logic               head_valid,
  input  logic               head_pop,
  output logic               credit_return
);

  import mem_pkg::*;

  localparam int PTR_W   = $clog2(`REQ_FIFO_DEPTH);
  localparam int COUNT_W = $clog2(`REQ_FIFO_DEPTH + 1);

  mem_req_t             entries [`REQ_FIFO_DEPTH];
  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W-1:0]     rd_ptr;
  logic [COUNT_W-1:0]   count;
  logic                 do_pop;

  // only a real entry hands back a credit
  assign do_pop        = head_pop && head_valid;
  assign credit_return = do_pop;

  assign head_valid = (count != '0);
  assign head       = entries[rd_ptr];

  // storage, no overflow check since issue never pushes without credit
  always_ff @(posedge clk)
  begin
    if (req_push)
      entries[wr_ptr] <= req;
  end

  // pointers wrap at the last entry
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (req_push)
        wr_ptr <= (wr_ptr == PTR_W'(`REQ_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == PTR_W'(`REQ_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      // occupancy holds when both happen together
      if (req_push && !do_pop)
        count <= count + 1'b1;
      else if (!req_push && do_pop)
        count <= count - 1'b1;
    end
  end

endmodule

/* verilog/mem_issue.sv */
`include "mem_defs.svh"

module mem_issue (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    cmd_valid,
  output logic                    cmd_ready,
  input  mem_pkg::mem_op_e        cmd_op,
  input  mem_pkg::wsrc_e          cmd_wsrc,
  input  logic [`MEM_ADDR_W-1:0]  cmd_addr,
  input  logic [`MEM_DATA_W-1:0]  cmd_reg_data,
  input  logic                    cmd_restore_flags,
  input  logic [`PC_W-1:0]        pc,
  input  logic [`FLAGS_W-1:0]     flags,
  input  logic                    credit_return,
  output mem_pkg::mem_req_t       req,
  output logic                    req_push
);

  import mem_pkg::*;

  localparam int CREDIT_W = $clog2(`REQ_FIFO_DEPTH + 1);

  logic [CREDIT_W-1:0]    credits;
  mem_tag_t               tag_q;
  logic [`MEM_DATA_W-1:0] wdata;

  // any credit left means the buffer has a free slot
  assign cmd_ready = (credits != '0);
  assign req_push  = cmd_valid && cmd_ready;

  // write word select, register value unless overridden
  always_comb
  begin
    wdata = cmd_reg_data;
    case (cmd_wsrc)
      wsrc_flags: wdata = {{(`MEM_DATA_W - `FLAGS_W){1'b0}}, flags};
      wsrc_pc_hi: wdata = pc[`PC_W-1:`PC_W/2];
      wsrc_pc_lo: wdata = pc[`PC_W/2-1:0];
      default:    wdata = cmd_reg_data;
    endcase
  end

  // request goes straight into the buffer on the accepting edge
  always_comb
  begin
    req.op            = cmd_op;
    req.addr          = cmd_addr;
    req.wdata         = wdata;
    req.restore_flags = cmd_restore_flags;
    req.tag           = tag_q;
  end

  // credit counter, spend and return can coincide
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      credits <= CREDIT_W'(`REQ_FIFO_DEPTH);
      tag_q   <= '0;
    end
    else
    begin
      if (req_push && !credit_return)
        credits <= credits - 1'b1;
      else if (!req_push && credit_return)
        credits <= credits + 1'b1;
      // tag steps once per accepted command
      if (req_push)
        tag_q <= tag_q + 1'b1;
    end
  end

endmodule

/* verilog/mem_pkg.sv */
`include "mem_defs.svh"

package mem_pkg;

  // memory command kind
  typedef enum logic [1:0] {
    op_load  = 2'd0,
    op_store = 2'd1,
    op_push  = 2'd2,
    op_pop   = 2'd3
  } mem_op_e;

  // where the write word comes from
  typedef enum logic [1:0] {
    wsrc_flags = 2'd0,
    wsrc_pc_hi = 2'd1,
    wsrc_pc_lo = 2'd2,
    wsrc_reg   = 2'd3
  } wsrc_e;

  // sequence number carried through to the response
  typedef logic [3:0] mem_tag_t;

  typedef struct packed {
    mem_op_e                 op;
    logic [`MEM_ADDR_W-1:0]  addr;
    logic [`MEM_DATA_W-1:0]  wdata;
    logic                    restore_flags;
    mem_tag_t                tag;
  } mem_req_t;

  // flags image as pushed by an interrupt-style save
  typedef struct packed {
    logic [`MEM_DATA_W-`FLAGS_W-1:0] pad;
    logic [`FLAGS_W-1:0]             flags;
  } flag_view_t;

  // one stored word, read as data or as a flags image
  typedef union packed {
    logic [`MEM_DATA_W-1:0] data;
    flag_view_t             flag_view;
  } mem_word_u;

  typedef struct packed {
    mem_op_e              op;
    mem_tag_t             tag;
    mem_word_u            word;
    logic                 flags_valid;
    logic [`FLAGS_W-1:0]  flags;
    logic                 fault;
  } mem_resp_t;

endpackage

/* verilog/mem_defs.svh */
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// data word and memory geometry
`define MEM_DATA_W 16
`define MEM_ADDR_W 9
`define MEM_DEPTH 512

// stack pointer needs one extra bit
// 0 means full, MEM_DEPTH means empty
`define SP_W 10

// request buffer entries, same as credits held by issue
`define REQ_FIFO_DEPTH 4

// pipeline side widths
`define PC_W 32
`define FLAGS_W 3

`endif
